/* Makefile */
TOP = pool_tb

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -f project.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST RESULT: PASS"

lint:
	verilator --lint-only --timing --assert -f project.f --top-module $(TOP)

clean:
	rm -rf obj_dir

/* hw/pool_ctrl.sv */
`timescale 1ns/100ps
`include "pool_settings.svh"

module pool_ctrl (
  input  logic               clk,
  input  logic               xrst,
  input  logic               in_start,
  input  logic               in_valid,
  input  logic [`LWIDTH-1:0] fea_size,
  input  logic [`LWIDTH-1:0] pool_size,
  output pool_pkg::pool_op_t op,
  output logic [`LWIDTH-1:0] col,
  output logic               wb,
  output logic               out_start,
  output logic               out_valid,
  output logic               out_stop
);
  import pool_pkg::*;

  ctrl_state_t        r_state;
  logic [`LWIDTH-1:0] r_fea_size;
  logic [`LWIDTH-1:0] r_pool_size;
  logic [`LWIDTH-1:0] r_x;
  logic [`LWIDTH-1:0] r_y;
  logic [`LWIDTH-1:0] r_exec_x;
  logic [`LWIDTH-1:0] r_exec_y;
  logic [`LWIDTH-1:0] r_out_x;
  logic [`D_POOL-1:0] r_dl_start;
  logic [`D_POOL-1:0] r_dl_emit;
  logic [`D_POOL-1:0] r_dl_stop;

  logic [`LWIDTH-1:0] fea_last;
  logic [`LWIDTH-1:0] pool_last;
  logic               pix;
  logic               row_end;
  logic               run_end;
  logic               win_last_row;
  logic               start_ev;
  logic               emit_ev;
  logic               stop_ev;
  pool_op_t           op_next;

  assign fea_last     = r_fea_size - 1'b1;
  assign pool_last    = r_pool_size - 1'b1;
  assign pix          = (r_state == S_ACTIVE) && in_valid;
  assign row_end      = (r_x == fea_last);
  assign run_end      = (r_exec_x == pool_last);
  assign win_last_row = (r_exec_y == pool_last);

  assign start_ev = (r_state == S_WAIT) && in_start;
  assign emit_ev  = pix && run_end && win_last_row;  // bottom right corner of a window.
  assign stop_ev  = pix && row_end && (r_y == fea_last);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // frame state and sizes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_state     <= S_WAIT;
      r_fea_size  <= '0;
      r_pool_size <= '0;
    end else begin
      case (r_state)
        S_WAIT: begin
          if (in_start) begin
            r_state     <= S_ACTIVE;
            r_fea_size  <= fea_size;
            r_pool_size <= pool_size;
          end
        end
        S_ACTIVE: begin
          if (stop_ev) r_state <= S_WAIT;  // the frame ends on its last pixel.
        end
        default: r_state <= S_WAIT;
      endcase
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // raster and window counters
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (!xrst || r_state == S_WAIT) begin
      r_x      <= '0;
      r_y      <= '0;
      r_exec_x <= '0;
      r_exec_y <= '0;
      r_out_x  <= '0;
    end else if (pix) begin
      r_exec_x <= run_end ? '0 : r_exec_x + 1'b1;
      if (row_end) begin
        r_x      <= '0;
        r_y      <= r_y + 1'b1;
        r_out_x  <= '0;
        r_exec_y <= win_last_row ? '0 : r_exec_y + 1'b1;
      end else begin
        r_x <= r_x + 1'b1;
        if (run_end) r_out_x <= r_out_x + 1'b1;  // next output column.
      end
    end
  end

  always_comb begin
    if (r_exec_x != '0)
      op_next = OP_MERGE;
    else if (r_exec_y != '0)
      op_next = OP_RESUME;
    else
      op_next = OP_INIT;
  end

  // commands to the max unit, one cycle behind the pixel.
  always_ff @(posedge clk) begin
    if (!xrst) begin
      op  <= OP_IDLE;
      col <= '0;
      wb  <= 1'b0;
    end else begin
      op  <= pix ? op_next : OP_IDLE;
      col <= r_out_x;
      wb  <= pix && run_end && !win_last_row;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // output framing
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_dl_start <= '0;
      r_dl_emit  <= '0;
      r_dl_stop  <= '0;
    end else begin
      r_dl_start[0] <= start_ev;
      r_dl_emit[0]  <= emit_ev;
      r_dl_stop[0]  <= stop_ev;
      for (int i = 1; i < `D_POOL; i++) begin
        r_dl_start[i] <= r_dl_start[i-1];
        r_dl_emit[i]  <= r_dl_emit[i-1];
        r_dl_stop[i]  <= r_dl_stop[i-1];
      end
    end
  end

  assign out_start = r_dl_start[`D_POOL-1];
  assign out_valid = r_dl_emit[`D_POOL-1];
  assign out_stop  = r_dl_stop[`D_POOL-1];

  // the window has to tile the map exactly, or the last pixel never closes a window.
  a_size_tiles: assert property (@(posedge clk) disable iff (!xrst)
    start_ev |-> (pool_size != '0 && (fea_size % pool_size) == '0));

  a_size_max: assert property (@(posedge clk) disable iff (!xrst)
    start_ev |-> (fea_size != '0 && fea_size <= `MAX_FEA));

  // pixels outside a frame would be dropped silently.
  a_no_stray_pixel: assert property (@(posedge clk) disable iff (!xrst)
    (r_state == S_WAIT) |-> !in_valid);

endmodule

/* hw/pool_max_unit.sv */
`timescale 1ns/100ps
`include "pool_settings.svh"

module pool_max_unit (
  input  logic                      clk,
  input  logic                      xrst,
  input  logic signed [`DWIDTH-1:0] in_data,
  input  pool_pkg::pool_op_t        op,
  input  logic        [`LWIDTH-1:0] col,
  input  logic                      wb,
  input  logic signed [`DWIDTH-1:0] rd_data,
  output logic                      wr_en,
  output logic        [`LWIDTH-1:0] wr_addr,
  output logic signed [`DWIDTH-1:0] wr_data,
  output logic signed [`DWIDTH-1:0] out_data
);
  import pool_pkg::*;

  logic signed [`DWIDTH-1:0] r_pix;  // pixel, aligned with op.
  logic signed [`DWIDTH-1:0] r_acc;  // running window maximum.
  logic signed [`DWIDTH-1:0] acc_next;

  function automatic logic signed [`DWIDTH-1:0] smax(
    input logic signed [`DWIDTH-1:0] a,
    input logic signed [`DWIDTH-1:0] b
  );
    return (a > b) ? a : b;
  endfunction

  always_ff @(posedge clk) begin
    r_pix <= in_data;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // accumulator
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    case (op)
      OP_INIT:   acc_next = r_pix;
      OP_RESUME: acc_next = smax(rd_data, r_pix);  // pick up the column from the row above.
      OP_MERGE:  acc_next = smax(r_acc, r_pix);
      default:   acc_next = r_acc;
    endcase
  end

  always_ff @(posedge clk) begin
    if (op != OP_IDLE) r_acc <= acc_next;
  end

  // out_valid from the controller says when this holds a finished window.
  assign out_data = r_acc;

  // the column maximum goes back to the buffer at the end of each run.
  assign wr_en   = wb;
  assign wr_addr = col;
  assign wr_data = acc_next;

  // a write-back carries the value of a real pixel, never a stale accumulator.
  a_wb_with_pixel: assert property (@(posedge clk) disable iff (!xrst)
    wr_en |-> (op != OP_IDLE));

endmodule

/* hw/pool_partial_buf.sv */
`timescale 1ns/100ps
`include "pool_settings.svh"

module pool_partial_buf (
  input  logic                      clk,
  input  logic                      wr_en,
  input  logic        [`LWIDTH-1:0] wr_addr,
  input  logic        [`LWIDTH-1:0] rd_addr,
  input  logic signed [`DWIDTH-1:0] wr_data,
  output logic signed [`DWIDTH-1:0] rd_data
);

  // address bits actually needed to select an entry.
  localparam int AW = $clog2(`MAX_FEA);

  // one column maximum per output column.
  // An entry holds the maximum of the window rows seen so far
  // in the current band of pool_size map rows.
  logic signed [`DWIDTH-1:0] mem [`MAX_FEA];

  logic [AW-1:0] wr_idx;
  logic [AW-1:0] rd_idx;

  assign wr_idx = wr_addr[AW-1:0];
  assign rd_idx = rd_addr[AW-1:0];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // storage
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_idx] <= wr_data;
    end
  end

  // read is combinational so the max unit can merge in the same cycle.
  assign rd_data = mem[rd_idx];

  // the upper address bits are dropped above, so they must be zero.
  a_wr_addr_range: assert property (@(posedge clk)
    wr_en |-> (wr_addr < `MAX_FEA));

endmodule

/* hw/pool_pkg.sv */
package pool_pkg;

  // controller state.
  typedef enum logic {
    S_WAIT,
    S_ACTIVE
  } ctrl_state_t;

  // per-pixel command from the controller to the max unit.
  typedef enum logic [1:0] {
    OP_IDLE,    // no pixel in this cycle.
    OP_INIT,    // first pixel of a window.
    OP_RESUME,  // first pixel of a column run below the top window row.
    OP_MERGE    // any other pixel of the window.
  } pool_op_t;

endpackage

/* hw/pool_settings.svh */
`ifndef POOL_SETTINGS_SVH
`define POOL_SETTINGS_SVH

// pixel width, two's complement signed.
`define DWIDTH 16

// width of map size, window size and every raster counter.
`define LWIDTH 8

// largest square map the stage accepts.
// It also sets the depth of the partial column buffer.
`define MAX_FEA 32

// depth of the start/valid/stop delay line.
// It has to match the latency of the max unit.
`define D_POOL 2

`endif

/* hw/pool_top.sv */
`timescale 1ns/100ps
`include "pool_settings.svh"

module pool_top (
  input  logic                      clk,
  input  logic                      xrst,
  input  logic                      in_start,
  input  logic                      in_valid,
  input  logic signed [`DWIDTH-1:0] in_data,
  input  logic        [`LWIDTH-1:0] fea_size,
  input  logic        [`LWIDTH-1:0] pool_size,
  output logic                      out_start,
  output logic                      out_valid,
  output logic                      out_stop,
  output logic signed [`DWIDTH-1:0] out_data
);
  import pool_pkg::*;

  pool_op_t                  op;
  logic        [`LWIDTH-1:0] col;
  logic                      wb;
  logic                      wr_en;
  logic        [`LWIDTH-1:0] wr_addr;
  logic signed [`DWIDTH-1:0] wr_data;
  logic signed [`DWIDTH-1:0] rd_data;

  pool_ctrl pool_ctrl_i (
    .clk       (clk),
    .xrst      (xrst),
    .in_start  (in_start),
    .in_valid  (in_valid),
    .fea_size  (fea_size),
    .pool_size (pool_size),
    .op        (op),
    .col       (col),
    .wb        (wb),
    .out_start (out_start),
    .out_valid (out_valid),
    .out_stop  (out_stop)
  );

  pool_max_unit pool_max_unit_i (
    .clk      (clk),
    .xrst     (xrst),
    .in_data  (in_data),
    .op       (op),
    .col      (col),
    .wb       (wb),
    .rd_data  (rd_data),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .out_data (out_data)
  );

  // the buffer is read at the column of the pixel now in the max unit.
  pool_partial_buf pool_partial_buf_i (
    .clk     (clk),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .rd_addr (col),
    .wr_data (wr_data),
    .rd_data (rd_data)
  );

endmodule

/* project.f */
+incdir+hw
hw/pool_pkg.sv
hw/pool_partial_buf.sv
hw/pool_max_unit.sv
hw/pool_ctrl.sv
hw/pool_top.sv
sim/pool_checker.sv
sim/pool_tb.sv

/* sim/pool_checker.sv */
`timescale 1ns/100ps
`include "pool_settings.svh"

module pool_checker (
  input  logic                      clk,
  input  logic                      xrst,
  input  logic                      out_start,
  input  logic                      out_valid,
  input  logic                      out_stop,
  input  logic signed [`DWIDTH-1:0] out_data,
  input  logic                      exp_start,
  input  logic                      exp_valid,
  input  logic signed [`DWIDTH-1:0] exp_data,
  input  logic                      exp_last,
  output int                        data_errs,
  output int                        frame_errs,
  output int                        pending
);

  int  cyc = 0;
  int  n_data = 0;
  int  n_frame = 0;
  int  n_res = 0;
  bit  frame_open = 1'b0;

  // expected arrival cycle of each out_start and each result.
  int                        start_due_q [$];
  int                        res_due_q [$];
  logic signed [`DWIDTH-1:0] res_data_q [$];
  logic                      res_last_q [$];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // compare
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always @(posedge clk) begin
    int                        due;
    logic signed [`DWIDTH-1:0] want;
    logic                      last;
    if (xrst) begin
      // the DUT answers two edges after it sees the input.
      if (exp_start) start_due_q.push_back(cyc + 2);
      if (exp_valid) begin
        res_due_q.push_back(cyc + 2);
        res_data_q.push_back(exp_data);
        res_last_q.push_back(exp_last);
      end
      if (out_start) begin
        if (start_due_q.size() == 0 || start_due_q[0] != cyc) begin
          n_frame++;
          $display("Framing fault at %0t: out_start came when none was due", $time);
        end else begin
          due = start_due_q.pop_front();
        end
        frame_open = 1'b1;
      end
      if (start_due_q.size() > 0 && start_due_q[0] < cyc) begin
        due = start_due_q.pop_front();
        n_frame++;
        $display("Framing fault at %0t: out_start is missing, due at cycle %0d", $time, due);
      end
      if (out_valid) begin
        if (!frame_open) begin
          n_frame++;
          $display("Framing fault at %0t: a result came without out_start", $time);
        end
        if (res_due_q.size() == 0) begin
          n_frame++;
          $display("Framing fault at %0t: more results than the frame holds", $time);
        end else begin
          due  = res_due_q.pop_front();
          want = res_data_q.pop_front();
          last = res_last_q.pop_front();
          n_res++;
          if (out_data !== want) begin
            n_data++;
            $display("Error: %0t ns: result %0d is %0d, expected %0d",
                     $time, n_res, out_data, want);
          end
          if (due != cyc) begin
            n_data++;
            $display("Error: %0t ns: result %0d came at cycle %0d, expected at cycle %0d",
                     $time, n_res, cyc, due);
          end
          if (out_stop != last) begin
            n_frame++;
            $display("Framing fault at %0t: out_stop is not on the last result", $time);
          end
        end
      end else if (out_stop) begin
        n_frame++;
        $display("Framing fault at %0t: out_stop came without a result", $time);
      end
      if (res_due_q.size() > 0 && res_due_q[0] < cyc) begin
        due = res_due_q.pop_front();
        want = res_data_q.pop_front();
        last = res_last_q.pop_front();
        n_frame++;
        $display("Framing fault at %0t: a result due at cycle %0d never came", $time, due);
      end
      if (out_stop) frame_open = 1'b0;
      cyc++;
    end
    data_errs  <= n_data;
    frame_errs <= n_frame;
    pending    <= start_due_q.size() + res_due_q.size();
  end

endmodule

/* sim/pool_tb.sv */
`timescale 1ns/100ps
`include "pool_settings.svh"

module pool_tb;

  // pixels over all frames, sets the watchdog limit.
  localparam int TOTAL_PIX = 4*4 + 6*6 + 5*5 + 32*32 + 8*8 + 9*9 + 4*4 + 2*2;
  localparam int LIMIT = TOTAL_PIX * 4 + 500;

  logic                      clk;
  logic                      xrst;
  logic                      in_start;
  logic                      in_valid;
  logic signed [`DWIDTH-1:0] in_data;
  logic        [`LWIDTH-1:0] fea_size;
  logic        [`LWIDTH-1:0] pool_size;
  logic                      out_start;
  logic                      out_valid;
  logic                      out_stop;
  logic signed [`DWIDTH-1:0] out_data;

  logic                      exp_start;
  logic                      exp_valid;
  logic signed [`DWIDTH-1:0] exp_data;
  logic                      exp_last;
  int                        data_errs;
  int                        frame_errs;
  int                        pending;

  logic        [31:0]        lcg_state = 32'h1aab30ab;
  logic signed [`DWIDTH-1:0] frame [$];   // current map in raster order.
  logic signed [`DWIDTH-1:0] exp_q [$];   // window maxima in raster order.

  pool_top pool_top_i (
    .clk       (clk),
    .xrst      (xrst),
    .in_start  (in_start),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .fea_size  (fea_size),
    .pool_size (pool_size),
    .out_start (out_start),
    .out_valid (out_valid),
    .out_stop  (out_stop),
    .out_data  (out_data)
  );

  pool_checker pool_checker_i (
    .clk        (clk),
    .xrst       (xrst),
    .out_start  (out_start),
    .out_valid  (out_valid),
    .out_stop   (out_stop),
    .out_data   (out_data),
    .exp_start  (exp_start),
    .exp_valid  (exp_valid),
    .exp_data   (exp_data),
    .exp_last   (exp_last),
    .data_errs  (data_errs),
    .frame_errs (frame_errs),
    .pending    (pending)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] rand_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // maximum of every pool_size square, scanned in raster order.
  function automatic void ref_pool(input int fs, input int ps);
    logic signed [`DWIDTH-1:0] m;
    for (int oy = 0; oy < fs / ps; oy++) begin
      for (int ox = 0; ox < fs / ps; ox++) begin
        m = frame[oy * ps * fs + ox * ps];
        for (int wy = 0; wy < ps; wy++) begin
          for (int wx = 0; wx < ps; wx++) begin
            if (frame[(oy * ps + wy) * fs + ox * ps + wx] > m)
              m = frame[(oy * ps + wy) * fs + ox * ps + wx];
          end
        end
        exp_q.push_back(m);
      end
    end
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stimulus
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic run_frame(input int fs, input int ps, input bit gaps);
    logic [31:0] r;
    int          n_gap;
    frame.delete();
    for (int i = 0; i < fs * fs; i++) begin
      r = rand_next();
      frame.push_back(r[23:8]);
    end
    ref_pool(fs, ps);
    in_start  <= 1'b1;
    exp_start <= 1'b1;
    fea_size  <= 8'(fs);
    pool_size <= 8'(ps);
    for (int y = 0; y < fs; y++) begin
      for (int x = 0; x < fs; x++) begin
        @(posedge clk);
        in_start  <= 1'b0;
        exp_start <= 1'b0;
        in_valid  <= 1'b0;
        exp_valid <= 1'b0;
        if (gaps) begin
          r = rand_next();
          n_gap = int'(r[17:16]);
          repeat (n_gap) @(posedge clk);
        end
        in_valid <= 1'b1;
        in_data  <= frame[y * fs + x];
        if (x % ps == ps - 1 && y % ps == ps - 1) begin  // this pixel closes a window.
          exp_valid <= 1'b1;
          exp_data  <= exp_q.pop_front();
          exp_last  <= (x == fs - 1) && (y == fs - 1);
        end
      end
    end
    @(posedge clk);
    in_valid  <= 1'b0;
    exp_valid <= 1'b0;
    // the next frame may start in the cycle after out_stop.
    while (!out_stop) @(posedge clk);
  endtask

  initial begin
    xrst      <= 1'b0;
    in_start  <= 1'b0;
    in_valid  <= 1'b0;
    in_data   <= '0;
    fea_size  <= '0;
    pool_size <= '0;
    exp_start <= 1'b0;
    exp_valid <= 1'b0;
    exp_data  <= '0;
    exp_last  <= 1'b0;
    repeat (4) @(posedge clk);
    xrst <= 1'b1;
    @(posedge clk);
    run_frame(4, 2, 1'b0);
    run_frame(6, 3, 1'b1);   // signed data with idle gaps.
    run_frame(5, 1, 1'b0);
    run_frame(32, 4, 1'b0);
    // frames of changing size, each started right after the last out_stop.
    run_frame(8, 2, 1'b0);
    run_frame(9, 3, 1'b1);
    run_frame(4, 4, 1'b0);
    run_frame(2, 1, 1'b0);
    while (pending != 0) @(posedge clk);
    repeat (2) @(posedge clk);
    $display("data errors: %0d, framing errors: %0d", data_errs, frame_errs);
    if (data_errs == 0 && frame_errs == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    repeat (LIMIT) @(posedge clk);
    $display("Timeout: the frames did not finish within %0d cycles", LIMIT);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule
